//--- build.f
source/ioBridgePkg.sv
source/fifoIf.sv
source/ioFifo.sv
source/reqAckPort.sv
source/ioBridge.sv
verification/ioBridge_assert.sv
verification/ioBridgeTb.sv

//--- verification/ioBridgeTb.sv
// directed tests of the byte bridge, expected bytes come from two queue models
// io handshakes follow the four-phase order, one outstanding req per side
module ioBridgeTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int testCount = 6;
	// worst case handshakes of one test and cycles allowed for each
	localparam int maxHandshakes = 32;
	localparam int cyclesPerHandshake = 20;
	localparam int ackLimit = 40;
	localparam int stallCycles = 12;

	logic in_clk;
	logic reset;
	logic [ioBridgePkg::dataWidth-1:0] cpuWriteData;
	logic cpuWrite;
	logic cpuFull;
	logic [ioBridgePkg::addrBits-1:0] cpuSpace;
	logic cpuRead;
	logic [ioBridgePkg::dataWidth-1:0] cpuReadData;
	logic cpuEmpty;
	logic [ioBridgePkg::addrBits-1:0] cpuUsed;
	logic ioWriteReq;
	logic [ioBridgePkg::dataWidth-1:0] ioWriteData;
	logic ioWriteAck;
	logic ioReadReq;
	logic [ioBridgePkg::dataWidth-1:0] ioReadData;
	logic ioReadAck;

	logic [31:0] lfsrState = 32'h380a;
	int errorCount = 0;
	int testStart;
	logic [7:0] toIoModel[$];
	logic [7:0] fromIoModel[$];
	logic [7:0] lastRead;
	logic [7:0] readExpected;

	ioBridge ioBridge_i (
		.in_clk(in_clk),
		.reset(reset),
		.cpuWriteData(cpuWriteData),
		.cpuWrite(cpuWrite),
		.cpuFull(cpuFull),
		.cpuSpace(cpuSpace),
		.cpuRead(cpuRead),
		.cpuReadData(cpuReadData),
		.cpuEmpty(cpuEmpty),
		.cpuUsed(cpuUsed),
		.ioWriteReq(ioWriteReq),
		.ioWriteData(ioWriteData),
		.ioWriteAck(ioWriteAck),
		.ioReadReq(ioReadReq),
		.ioReadData(ioReadData),
		.ioReadAck(ioReadAck)
	);

	initial begin
		in_clk = 1'b0;
		forever #50 in_clk = ~in_clk;
	end

	// x^32 + x^22 + x^2 + x + 1, new bit enters at the bottom
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// eight fresh bits per byte
	function automatic logic [7:0] randomByte();
		logic [7:0] b;
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsrState = lfsrStep(lfsrState);
			b = {b[6:0], lfsrState[0]};
		end
		return b;
	endfunction

	// value errors plus failures of the bound checks
	function automatic int failureTotal();
		return errorCount + ioBridge_i.checks.failures;
	endfunction

	function automatic logic ackOf(input bit readSide);
		return readSide ? ioReadAck : ioWriteAck;
	endfunction

	task automatic compareValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else begin
			$display("MISMATCH %0t %s expected %0h actual %0h", $time, name, expected, actual);
			errorCount++;
		end
	endtask

	// drive point is 5 ns after the rising edge
	task automatic nextCycle();
		@(posedge in_clk);
		#5;
	endtask

	task automatic endTest(input string name);
		int n;
		n = failureTotal() - testStart;
		$display("test %-14s %s, %0d errors", name, (n == 0) ? "ok" : "failed", n);
	endtask

	// waits for ack to reach level, popped byte is checked while ack stays high
	task automatic waitAck(input bit readSide, input logic level);
		int waited;
		waited = 0;
		while (ackOf(readSide) !== level && waited < ackLimit) begin
			if (readSide && ioReadAck) begin
				compareValue("ioReadData", readExpected, ioReadData);
			end
			nextCycle();
			waited++;
		end
		if (ackOf(readSide) !== level) begin
			$display("%s ack did not go to %0b within %0d cycles at %0t",
				readSide ? "io read" : "io write", level, ackLimit, $time);
			errorCount++;
		end
	endtask

	task automatic cpuWriteByte(input logic [7:0] value);
		cpuWriteData = value;
		cpuWrite = 1'b1;
		nextCycle();
		cpuWrite = 1'b0;
		toIoModel.push_back(value);
	endtask

	task automatic cpuReadByte();
		compareValue("cpuReadData", fromIoModel[0], cpuReadData);
		cpuRead = 1'b1;
		nextCycle();
		cpuRead = 1'b0;
		lastRead = fromIoModel.pop_front();
	endtask

	// rest of a write handshake once req is up
	task automatic finishWrite();
		waitAck(1'b0, 1'b1);
		fromIoModel.push_back(ioWriteData);
		ioWriteReq = 1'b0;
		waitAck(1'b0, 1'b0);
	endtask

	task automatic finishRead();
		waitAck(1'b1, 1'b1);
		if (toIoModel.size() == 0) begin
			$display("io read was acked at %0t with no byte queued", $time);
			errorCount++;
		end else begin
			readExpected = toIoModel.pop_front();
		end
		compareValue("ioReadData", readExpected, ioReadData);
		ioReadReq = 1'b0;
		waitAck(1'b1, 1'b0);
	endtask

	task automatic ioWriteByte(input logic [7:0] value);
		ioWriteData = value;
		ioWriteReq = 1'b1;
		finishWrite();
	endtask

	task automatic ioReadByte();
		ioReadReq = 1'b1;
		finishRead();
	endtask

	initial begin
		reset = 1'b1;
		cpuWriteData = '0;
		cpuWrite = 1'b0;
		cpuRead = 1'b0;
		ioWriteReq = 1'b0;
		ioWriteData = '0;
		ioReadReq = 1'b0;
		repeat (16) @(posedge in_clk);
		#5;
		reset = 1'b0;

		testStart = failureTotal();
		compareValue("ioReadAck", 0, ioReadAck);
		compareValue("ioWriteAck", 0, ioWriteAck);
		compareValue("cpuEmpty", 1, cpuEmpty);
		compareValue("cpuFull", 0, cpuFull);
		compareValue("cpuUsed", 0, cpuUsed);
		compareValue("cpuSpace", 15, cpuSpace);
		endTest("reset values");

		testStart = failureTotal();
		for (int i = 0; i < 8; i++) begin
			cpuWriteByte(randomByte());
		end
		compareValue("cpuSpace", 7, cpuSpace);
		for (int i = 0; i < 8; i++) begin
			ioReadByte();
		end
		compareValue("cpuSpace", 15, cpuSpace);
		endTest("cpu to io");

		testStart = failureTotal();
		for (int i = 0; i < 8; i++) begin
			ioWriteByte(randomByte());
		end
		compareValue("cpuUsed", 8, cpuUsed);
		for (int i = 0; i < 8; i++) begin
			cpuReadByte();
		end
		compareValue("cpuEmpty", 1, cpuEmpty);
		compareValue("cpuReadData", lastRead, cpuReadData);
		nextCycle();
		compareValue("cpuReadData", lastRead, cpuReadData);
		endTest("io to cpu");

		testStart = failureTotal();
		for (int i = 0; i < 15; i++) begin
			cpuWriteByte(randomByte());
		end
		compareValue("cpuFull", 1, cpuFull);
		compareValue("cpuSpace", 0, cpuSpace);
		ioReadByte();
		compareValue("cpuFull", 0, cpuFull);
		compareValue("cpuSpace", 1, cpuSpace);
		while (toIoModel.size() > 0) begin
			ioReadByte();
		end
		endTest("toIo full");

		// 16th io write must stall until the CPU frees a slot
		testStart = failureTotal();
		for (int i = 0; i < 15; i++) begin
			ioWriteByte(randomByte());
		end
		compareValue("cpuUsed", 15, cpuUsed);
		ioWriteData = randomByte();
		ioWriteReq = 1'b1;
		repeat (stallCycles) begin
			nextCycle();
			compareValue("ioWriteAck", 0, ioWriteAck);
		end
		cpuReadByte();
		finishWrite();
		while (fromIoModel.size() > 0) begin
			cpuReadByte();
		end
		compareValue("cpuEmpty", 1, cpuEmpty);
		endTest("fromIo stall");

		// io read on an empty toIo waits for the CPU byte
		testStart = failureTotal();
		ioReadReq = 1'b1;
		repeat (stallCycles) begin
			nextCycle();
			compareValue("ioReadAck", 0, ioReadAck);
		end
		cpuWriteByte(randomByte());
		finishRead();
		endTest("read stall");

		$display("%0d tests, %0d value errors, %0d assertion failures",
			testCount, errorCount, ioBridge_i.checks.failures);
		if (failureTotal() == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// limit from the test count and the slowest handshake
	initial begin
		repeat (16 + testCount * maxHandshakes * cyclesPerHandshake) @(posedge in_clk);
		$display("watchdog expired, a test stopped making progress");
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- verification/ioBridge_assert.sv
// protocol and flag checks bound into the bridge top level
// assumes the io peer holds req until ack and waits for ack low before a new req
module ioBridge_assert (
	input logic in_clk,
	input logic reset,
	input logic ioReadReq,
	input logic ioReadAck,
	input logic ioWriteReq,
	input logic ioWriteAck,
	input logic cpuWrite,
	input logic cpuFull,
	input logic cpuRead,
	input logic cpuEmpty,
	input logic toIoEmpty,
	input logic fromIoFull,
	input logic [ioBridgePkg::addrBits-1:0] toIoUsed,
	input logic [ioBridgePkg::addrBits-1:0] cpuSpace,
	input logic [ioBridgePkg::addrBits-1:0] cpuUsed,
	input logic [ioBridgePkg::addrBits-1:0] fromIoSpace
);
	timeunit 1ns;
	timeprecision 1ps;

	// read by the testbench for its final count
	int failures = 0;

	// ack may only rise while req is held high
	assert property (@(posedge in_clk) disable iff (reset)
		(!ioReadReq && !ioReadAck |=> !ioReadAck) and
		(!ioWriteReq && !ioWriteAck |=> !ioWriteAck))
		else begin
			$error("ack rose without req");
			failures++;
		end

	// ack holds while req is still high
	assert property (@(posedge in_clk) disable iff (reset)
		(ioReadReq && ioReadAck |=> ioReadAck) and
		(ioWriteReq && ioWriteAck |=> ioWriteAck))
		else begin
			$error("ack fell while req was high");
			failures++;
		end

	// fill level and free room always add up to the usable depth
	assert property (@(posedge in_clk) disable iff (reset)
		(int'(toIoUsed) + int'(cpuSpace) == ioBridgePkg::fifoSlots - 1) &&
		(int'(cpuUsed) + int'(fromIoSpace) == ioBridgePkg::fifoSlots - 1))
		else begin
			$error("used plus space differs from the FIFO depth");
			failures++;
		end

	// one free slot keeps full and empty apart
	assert property (@(posedge in_clk) disable iff (reset)
		!(cpuFull && toIoEmpty) && !(fromIoFull && cpuEmpty))
		else begin
			$error("a FIFO reports full and empty together");
			failures++;
		end

	// CPU side has no guard in the core
	assert property (@(posedge in_clk) disable iff (reset)
		(cpuWrite |-> !cpuFull) and (cpuRead |-> !cpuEmpty))
		else begin
			$error("CPU accessed a FIFO against its flag");
			failures++;
		end

endmodule

bind ioBridge ioBridge_assert checks (
	.in_clk(in_clk),
	.reset(reset),
	.ioReadReq(ioReadReq),
	.ioReadAck(ioReadAck),
	.ioWriteReq(ioWriteReq),
	.ioWriteAck(ioWriteAck),
	.cpuWrite(cpuWrite),
	.cpuFull(cpuFull),
	.cpuRead(cpuRead),
	.cpuEmpty(cpuEmpty),
	.toIoEmpty(toIoBus.empty),
	.fromIoFull(fromIoBus.full),
	.toIoUsed(toIoUsed),
	.cpuSpace(cpuSpace),
	.cpuUsed(cpuUsed),
	.fromIoSpace(fromIoSpace)
);

//--- source/ioBridge.sv
// byte bridge between a CPU bus and an io controller, single in_clk domain
// CPU must not write while cpuFull nor read while cpuEmpty
module ioBridge (
	input logic in_clk,
	input logic reset,

	// CPU write side into the toIo FIFO
	input logic [ioBridgePkg::dataWidth-1:0] cpuWriteData,
	input logic cpuWrite,
	output logic cpuFull,
	output logic [ioBridgePkg::addrBits-1:0] cpuSpace,

	// CPU read side out of the fromIo FIFO
	input logic cpuRead,
	output logic [ioBridgePkg::dataWidth-1:0] cpuReadData,
	output logic cpuEmpty,
	output logic [ioBridgePkg::addrBits-1:0] cpuUsed,

	// io controller writes into fromIo
	input logic ioWriteReq,
	input logic [ioBridgePkg::dataWidth-1:0] ioWriteData,
	output logic ioWriteAck,

	// io controller reads out of toIo
	input logic ioReadReq,
	output logic [ioBridgePkg::dataWidth-1:0] ioReadData,
	output logic ioReadAck
);

	// FIFO to port links, one per direction
	fifoIf toIoBus ();
	fifoIf fromIoBus ();

	// counters of the FIFO sides that have no top level port
	// kept visible for the bound checks
	logic [ioBridgePkg::addrBits-1:0] toIoUsed;
	logic [ioBridgePkg::addrBits-1:0] fromIoSpace;

	// CPU to io direction
	// CPU pushes through the side inputs, the read port pops over the bus
	ioFifo toIoFifo (
		.in_clk(in_clk),
		.reset(reset),
		.bus(toIoBus.core),
		.otherPush(cpuWrite),
		.otherPop(1'b0),
		.otherData(cpuWriteData),
		.used(toIoUsed),
		.space(cpuSpace)
	);

	// io to CPU direction
	// the write port pushes over the bus, CPU pops through the side input
	ioFifo fromIoFifo (
		.in_clk(in_clk),
		.reset(reset),
		.bus(fromIoBus.core),
		.otherPush(1'b0),
		.otherPop(cpuRead),
		.otherData('0),
		.used(cpuUsed),
		.space(fromIoSpace)
	);

	// io controller read handshake
	reqAckPort #(
		.dir(ioBridgePkg::portPop)
	) ioReadPort (
		.in_clk(in_clk),
		.reset(reset),
		.bus(toIoBus.port),
		.req(ioReadReq),
		.data('0),
		.ack(ioReadAck),
		.readData(ioReadData)
	);

	// io controller write handshake, echo of the written byte is not needed
	reqAckPort #(
		.dir(ioBridgePkg::portPush)
	) ioWritePort (
		.in_clk(in_clk),
		.reset(reset),
		.bus(fromIoBus.port),
		.req(ioWriteReq),
		.data(ioWriteData),
		.ack(ioWriteAck),
		.readData()
	);

	// CPU status and read data straight from the cores
	assign cpuFull = toIoBus.full;
	assign cpuEmpty = fromIoBus.empty;
	assign cpuReadData = fromIoBus.headData;

endmodule

//--- source/reqAckPort.sv
// four-phase req/ack slave, req may be asynchronous, ack is a clean flop output
// peer must hold write data stable from before req rises until ack is seen
module reqAckPort #(
	parameter ioBridgePkg::portDir dir = ioBridgePkg::portPush
) (
	input logic in_clk,
	input logic reset,
	fifoIf.port bus,
	input logic req,
	input logic [ioBridgePkg::dataWidth-1:0] data,
	output logic ack,
	output logic [ioBridgePkg::dataWidth-1:0] readData
);

	// two-flop synchronizer plus one delay stage for edge detection
	logic reqMeta;
	logic reqSync;
	logic reqLast;
	logic reqRise;

	// handshake FSM
	ioBridgePkg::portState state;

	// FIFO can take part in a move this cycle
	logic canMove;
	logic moveByte;

	// bring req into the local clock domain
	always_ff @(posedge in_clk) begin
		if (reset) begin
			reqMeta <= 1'b0;
			reqSync <= 1'b0;
			reqLast <= 1'b0;
		end else begin
			reqMeta <= req;
			reqSync <= reqMeta;
			reqLast <= reqSync;
		end
	end

	// act only on the rising edge of the synchronized req
	assign reqRise = reqSync && !reqLast;

	// the single place where full or empty gates the io side
	assign canMove = (dir == ioBridgePkg::portPush) ? !bus.full : !bus.empty;

	// one byte per handshake, issued in the transfer state
	assign moveByte = (state == ioBridgePkg::transfer) && canMove;

	assign bus.push = moveByte && (dir == ioBridgePkg::portPush);
	assign bus.pop = moveByte && (dir == ioBridgePkg::portPop);
	assign bus.pushData = data;

	// ack rises on the edge that commits the move
	// and falls one cycle after req is seen low
	always_ff @(posedge in_clk) begin
		if (reset) begin
			state <= ioBridgePkg::idle;
			ack <= 1'b0;
		end else begin
			case (state)
				ioBridgePkg::idle: begin
					if (reqRise) begin
						state <= ioBridgePkg::transfer;
					end
				end
				ioBridgePkg::transfer: begin
					// stays here with ack low while the FIFO cannot move
					if (canMove) begin
						state <= ioBridgePkg::ackHigh;
						ack <= 1'b1;
					end
				end
				ioBridgePkg::ackHigh: begin
					if (!reqSync) begin
						state <= ioBridgePkg::waitReqLow;
					end
				end
				ioBridgePkg::waitReqLow: begin
					state <= ioBridgePkg::idle;
					ack <= 1'b0;
				end
				default: begin
					state <= ioBridgePkg::idle;
					ack <= 1'b0;
				end
			endcase
		end
	end

	// popped byte is captured together with ack so it is valid while ack is high
	// a push port keeps the last byte it wrote instead
	always_ff @(posedge in_clk) begin
		if (moveByte) begin
			readData <= (dir == ioBridgePkg::portPop) ? bus.headData : data;
		end
	end

endmodule

//--- source/ioFifo.sv
// single-clock circular FIFO, holds at most fifoSlots-1 bytes
// no overflow or underflow guard, callers check full and empty first
module ioFifo (
	input logic in_clk,
	input logic reset,
	fifoIf.core bus,
	input logic otherPush,
	input logic otherPop,
	input logic [ioBridgePkg::dataWidth-1:0] otherData,
	output logic [ioBridgePkg::addrBits-1:0] used,
	output logic [ioBridgePkg::addrBits-1:0] space
);

	// byte storage, no reset on the payload
	logic [ioBridgePkg::dataWidth-1:0] mem [ioBridgePkg::fifoSlots];

	// pointers wrap naturally at fifoSlots
	logic [ioBridgePkg::addrBits-1:0] writePtr;
	logic [ioBridgePkg::addrBits-1:0] readPtr;

	// neighbours of the pointers
	logic [ioBridgePkg::addrBits-1:0] writeNext;
	logic [ioBridgePkg::addrBits-1:0] readNext;
	logic [ioBridgePkg::addrBits-1:0] readPrev;

	// merged strobes and write data
	logic doPush;
	logic doPop;
	logic [ioBridgePkg::dataWidth-1:0] writeByte;

	assign writeNext = writePtr + 1'b1;
	assign readNext = readPtr + 1'b1;
	assign readPrev = readPtr - 1'b1;

	// only one source per direction is live at the top level
	assign doPush = bus.push || otherPush;
	assign doPop = bus.pop || otherPop;

	// the port wins if both ever strobe together
	assign writeByte = bus.push ? bus.pushData : otherData;

	// full leaves one slot unused
	assign bus.full = (readPtr == writeNext);
	assign bus.empty = (readPtr == writePtr);

	// fill level and free room from the pointer difference
	assign used = writePtr - readPtr;
	assign space = readPtr - writePtr - 1'b1;

	// head of queue, or the last byte read when drained
	assign bus.headData = bus.empty ? mem[readPrev] : mem[readPtr];

	// storage write
	always_ff @(posedge in_clk) begin
		if (doPush) begin
			mem[writePtr] <= writeByte;
		end
	end

	// write pointer
	always_ff @(posedge in_clk) begin
		if (reset) begin
			writePtr <= '0;
		end else if (doPush) begin
			writePtr <= writeNext;
		end
	end

	// read pointer
	always_ff @(posedge in_clk) begin
		if (reset) begin
			readPtr <= '0;
		end else if (doPop) begin
			readPtr <= readNext;
		end
	end

endmodule

//--- source/fifoIf.sv
// links one FIFO core to one req/ack port
// all signals live in the in_clk domain
interface fifoIf;

	// byte offered by the port when pushing
	logic [ioBridgePkg::dataWidth-1:0] pushData;

	// single-cycle write strobe from the port
	logic push;

	// single-cycle read strobe from the port
	logic pop;

	// current head of the FIFO
	// holds the last byte read while empty
	logic [ioBridgePkg::dataWidth-1:0] headData;

	// status from the core, derived from the pointers
	logic empty;
	logic full;

	// FIFO side
	modport core (
		input pushData,
		input push,
		input pop,
		output headData,
		output empty,
		output full
	);

	// handshake port side
	modport port (
		output pushData,
		output push,
		output pop,
		input headData,
		input empty,
		input full
	);

endinterface

//--- source/ioBridgePkg.sv
// shared sizes and enums for the byte bridge
// changing addrBits resizes both FIFOs, usable depth stays one below fifoSlots
package ioBridgePkg;

	// every data path is one byte wide
	localparam int dataWidth = 8;

	// pointer width, also the width of used and space
	localparam int addrBits = 4;

	// storage entries per FIFO
	// one slot is always left free so full and empty differ
	localparam int fifoSlots = 1 << addrBits;

	// four-phase handshake FSM of a req/ack port
	typedef enum logic [1:0] {
		// waiting for a rising req
		idle,
		// byte move pending, stalls here on back-pressure
		transfer,
		// ack is high, waiting for the peer to drop req
		ackHigh,
		// req seen low, ack drops on the way out
		waitReqLow
	} portState;

	// direction of a req/ack port relative to its FIFO
	typedef enum logic {
		// the port writes into the FIFO
		portPush,
		// the port reads out of the FIFO
		portPop
	} portDir;

endpackage
